// File: all.f
source/spu_isa_pkg.sv
source/spu_issue_pkg.sv
source/instr_decoder.sv
source/write_tracker.sv
source/pair_hazard_check.sv
source/issue_control.sv
source/spu_decode.sv
dv/spu_decode_assertions.sv
dv/spu_decode_tb.sv

// File: dv/spu_decode_assertions.sv
`timescale 1ns/10ps

module spu_decode_assertions (
	input logic                       clk,
	input logic                       reset,
	input logic                       branch_taken,
	input spu_issue_pkg::decoded_op_t even_slot,
	input spu_issue_pkg::decoded_op_t odd_slot,
	input logic                       stall
);

	even_pipe_only: assert property (@(posedge clk) disable iff (reset)
		!(even_slot.valid && even_slot.unit >= spu_issue_pkg::unit_perm))
		else $error("even slot holds an odd unit");

	odd_pipe_only: assert property (@(posedge clk) disable iff (reset)
		!(odd_slot.valid && odd_slot.unit inside {spu_issue_pkg::unit_fp,
		spu_issue_pkg::unit_fx2, spu_issue_pkg::unit_byte, spu_issue_pkg::unit_fx1}))
		else $error("odd slot holds an even unit");

	no_shared_target: assert property (@(posedge clk) disable iff (reset)
		!(even_slot.valid && even_slot.reg_write && odd_slot.valid && odd_slot.reg_write
		&& even_slot.rt == odd_slot.rt))
		else $error("both slots write one register");

	flush_after_branch: assert property (@(posedge clk) disable iff (reset)
		branch_taken |=> (!even_slot.valid && !odd_slot.valid && stall))
		else $error("branch did not flush the stage");

endmodule

bind spu_decode spu_decode_assertions spu_decode_assertions_i (.*);

// File: dv/spu_decode_tb.sv
`timescale 1ns/10ps

module spu_decode_tb;

	localparam int FP_LAT  = 6;
	localparam int FX1_LAT = 2;

	typedef struct packed {
		logic [31:0]          first;
		logic [31:0]          second;
		logic [7:0]           pc;
		logic                 br;
		logic [7:0]           bpc;
		logic                 ev_valid;
		spu_isa_pkg::opcode_t ev_op;
		logic [6:0]           ev_rt;
		logic                 od_valid;
		spu_isa_pkg::opcode_t od_op;
		logic [6:0]           od_rt;
		logic                 imm_chk;
		spu_isa_pkg::imm_t    ev_imm;
		spu_isa_pkg::imm_t    od_imm;
		logic                 stall;
		logic [7:0]           spc;
	} row_t;

	logic                       clk;
	logic                       reset;
	spu_issue_pkg::instr_pair_t instr_pair;
	spu_isa_pkg::pc_t           pc;
	logic                       branch_taken;
	spu_isa_pkg::pc_t           branch_pc;
	spu_issue_pkg::decoded_op_t even_slot;
	spu_issue_pkg::decoded_op_t odd_slot;
	logic                       stall;
	spu_isa_pkg::pc_t           stall_pc;

	row_t rows [$];
	int   errors = 0;
	int   tgt_cnt = 0;
	logic [7:0] pc_cnt = 8'h10;

	spu_decode #(.FP_LATENCY(FP_LAT), .FX1_LATENCY(FX1_LAT)) spu_decode_i (.clk, .reset,
		.instr_pair, .pc, .branch_taken, .branch_pc, .even_slot, .odd_slot, .stall, .stall_pc);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	function automatic logic [31:0] ri10(input spu_isa_pkg::opcode_t op, input logic [9:0] imm,
		input logic [6:0] ra, input logic [6:0] rt);
		return {op[0:7], imm, ra, rt};
	endfunction

	function automatic logic [31:0] rr(input spu_isa_pkg::opcode_t op, input logic [6:0] rb,
		input logic [6:0] ra, input logic [6:0] rt);
		return {op, rb, ra, rt};
	endfunction

	function automatic logic [31:0] ri16(input spu_isa_pkg::opcode_t op, input logic [15:0] imm,
		input logic [6:0] rt);
		return {op[0:8], imm, rt};
	endfunction

	function automatic logic [31:0] ri18(input spu_isa_pkg::opcode_t op, input logic [17:0] imm,
		input logic [6:0] rt);
		return {op[0:6], imm, rt};
	endfunction

	function automatic logic [6:0] new_target();
		tgt_cnt++;
		return 7'(1 + (tgt_cnt % 90));    // targets stay below 100
	endfunction

	function automatic logic [6:0] src();
		return 7'(100 + ($urandom % 28));    // never written
	endfunction

	function automatic logic [7:0] next_pc();
		pc_cnt = pc_cnt + 8'd4;
		return pc_cnt;
	endfunction

	// outputs hold their reset values and reset is low
	function automatic logic stage_idle();
		return reset === 1'b0 && stall === 1'b0 && stall_pc === '0 &&
			even_slot.valid === 1'b0 && odd_slot.valid === 1'b0;
	endfunction

	function automatic row_t mk(input logic [31:0] w1, input logic [31:0] w2, input logic [7:0] p);
		row_t r;
		r = '0;
		r.first = w1;
		r.second = w2;
		r.pc = p;
		return r;
	endfunction

	function automatic row_t with_even(input row_t r, input spu_isa_pkg::opcode_t op,
		input logic [6:0] rt);
		r.ev_valid = 1'b1;
		r.ev_op = op;
		r.ev_rt = rt;
		return r;
	endfunction

	function automatic row_t with_odd(input row_t r, input spu_isa_pkg::opcode_t op,
		input logic [6:0] rt);
		r.od_valid = 1'b1;
		r.od_op = op;
		r.od_rt = rt;
		return r;
	endfunction

	function automatic row_t set_imms(input row_t r, input logic [17:0] ev_imm,
		input logic [17:0] od_imm);
		r.imm_chk = 1'b1;
		r.ev_imm = ev_imm;
		r.od_imm = od_imm;
		return r;
	endfunction

	function automatic row_t with_stall(input row_t r, input logic [7:0] spc);
		r.stall = 1'b1;
		r.spc = spc;
		return r;
	endfunction

	// dependent lqd reading t1, either inside the pair or one row later
	task automatic raw_case(input int lat, input bit use_fp, input bit same_pair);
		logic [6:0] t1;
		logic [6:0] t2;
		logic [7:0] p;
		logic [7:0] q;
		logic [31:0] w1;
		logic [31:0] w2;
		spu_isa_pkg::opcode_t pop;
		t1 = new_target();
		t2 = new_target();
		p = next_pc();
		pop = use_fp ? spu_isa_pkg::OP_FA : spu_isa_pkg::OP_AI;
		w1 = use_fp ? rr(pop, src(), src(), t1) : ri10(pop, 10'($urandom), src(), t1);
		w2 = ri10(spu_isa_pkg::OP_LQD, 10'($urandom), t1, t2);
		if (same_pair) begin
			rows.push_back(with_stall(with_even(mk(w1, w2, p), pop, t1), p));
			q = p;
		end else begin
			rows.push_back(with_even(mk(w1, 0, p), pop, t1));
			q = next_pc();
			rows.push_back(with_stall(mk(w2, 0, q), q));
		end
		for (int k = same_pair ? 1 : 2; k < lat; k++) begin
			rows.push_back(with_stall(mk(0, 0, next_pc()), q));
		end
		rows.push_back(with_odd(mk(0, 0, next_pc()), spu_isa_pkg::OP_LQD, t2));
	endtask

	task automatic build_table();
		logic [6:0] t1;
		logic [6:0] t2;
		logic [7:0] p;
		logic [31:0] w1;
		logic [31:0] w2;
		logic [17:0] i1;
		logic [17:0] i2;
		row_t r;
		for (int i = 0; i < 10; i++) begin
			t1 = new_target();
			t2 = new_target();
			p = next_pc();
			i1 = 18'($urandom);
			i2 = 18'($urandom);
			case (i % 5)
				0: begin
					w1 = ri10(spu_isa_pkg::OP_AI, i1[9:0], src(), t1);
					w2 = ri10(spu_isa_pkg::OP_LQD, i2[9:0], src(), t2);
					r = with_odd(with_even(mk(w1, w2, p), spu_isa_pkg::OP_AI, t1),
						spu_isa_pkg::OP_LQD, t2);
					r = set_imms(r, {{8{i1[9]}}, i1[9:0]}, {{8{i2[9]}}, i2[9:0]});
				end
				1: begin    // odd word first
					w1 = ri10(spu_isa_pkg::OP_LQD, i1[9:0], src(), t1);
					w2 = ri10(spu_isa_pkg::OP_AI, i2[9:0], src(), t2);
					r = with_odd(with_even(mk(w1, w2, p), spu_isa_pkg::OP_AI, t2),
						spu_isa_pkg::OP_LQD, t1);
					r = set_imms(r, {{8{i2[9]}}, i2[9:0]}, {{8{i1[9]}}, i1[9:0]});
				end
				2: begin
					w1 = rr(spu_isa_pkg::OP_A, src(), src(), t1);
					w2 = rr(spu_isa_pkg::OP_SHLQBI, src(), src(), t2);
					r = with_odd(with_even(mk(w1, w2, p), spu_isa_pkg::OP_A, t1),
						spu_isa_pkg::OP_SHLQBI, t2);
					r = set_imms(r, '0, '0);
				end
				3: begin
					w1 = ri18(spu_isa_pkg::OP_ILA, i1, t1);
					w2 = ri16(spu_isa_pkg::OP_LQA, i2[15:0], t2);
					r = with_odd(with_even(mk(w1, w2, p), spu_isa_pkg::OP_ILA, t1),
						spu_isa_pkg::OP_LQA, t2);
					r = set_imms(r, i1, {{2{i2[15]}}, i2[15:0]});
				end
				default: begin
					w1 = rr(spu_isa_pkg::OP_GBB, src(), src(), t1);
					w2 = rr(spu_isa_pkg::OP_FA, src(), src(), t2);
					r = with_odd(with_even(mk(w1, w2, p), spu_isa_pkg::OP_FA, t2),
						spu_isa_pkg::OP_GBB, t1);
					r = set_imms(r, '0, '0);
				end
			endcase
			rows.push_back(r);
		end
		// structural, two even words
		t1 = new_target();
		t2 = new_target();
		p = next_pc();
		w1 = ri10(spu_isa_pkg::OP_AI, 10'($urandom), src(), t1);
		w2 = rr(spu_isa_pkg::OP_A, src(), src(), t2);
		rows.push_back(with_stall(with_even(mk(w1, w2, p), spu_isa_pkg::OP_AI, t1), p));
		rows.push_back(with_even(mk(0, 0, next_pc()), spu_isa_pkg::OP_A, t2));
		// waw on one target
		t1 = new_target();
		p = next_pc();
		w1 = ri10(spu_isa_pkg::OP_AI, 10'($urandom), src(), t1);
		w2 = ri10(spu_isa_pkg::OP_LQD, 10'($urandom), src(), t1);
		rows.push_back(with_stall(with_even(mk(w1, w2, p), spu_isa_pkg::OP_AI, t1), p));
		rows.push_back(with_odd(mk(0, 0, next_pc()), spu_isa_pkg::OP_LQD, t1));
		raw_case(FX1_LAT, 1'b0, 1'b1);
		raw_case(FX1_LAT, 1'b0, 1'b0);
		raw_case(FP_LAT, 1'b1, 1'b0);
		// flush of a fresh pair, then of a held word
		p = next_pc();
		r = mk(ri10(spu_isa_pkg::OP_AI, 10'($urandom), src(), new_target()), 0, next_pc());
		r.br = 1'b1;
		r.bpc = p;
		rows.push_back(with_stall(r, p));
		rows.push_back(mk(0, 0, next_pc()));
		t1 = new_target();
		t2 = new_target();
		p = next_pc();
		w1 = ri10(spu_isa_pkg::OP_AI, 10'($urandom), src(), t1);
		w2 = rr(spu_isa_pkg::OP_A, src(), src(), t2);
		rows.push_back(with_stall(with_even(mk(w1, w2, p), spu_isa_pkg::OP_AI, t1), p));
		r = mk(0, 0, next_pc());
		r.br = 1'b1;
		r.bpc = 8'hc4;
		rows.push_back(with_stall(r, 8'hc4));
		rows.push_back(mk(0, 0, next_pc()));
	endtask

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_row(input row_t r);
		compare("even_slot.valid", 32'(even_slot.valid), 32'(r.ev_valid));
		if (r.ev_valid) begin
			compare("even_slot.opcode", 32'(even_slot.opcode), 32'(r.ev_op));
			compare("even_slot.rt", 32'(even_slot.rt), 32'(r.ev_rt));
		end
		if (r.ev_valid && r.imm_chk) begin
			compare("even_slot.imm", 32'(even_slot.imm), 32'(r.ev_imm));
		end
		compare("odd_slot.valid", 32'(odd_slot.valid), 32'(r.od_valid));
		if (r.od_valid) begin
			compare("odd_slot.opcode", 32'(odd_slot.opcode), 32'(r.od_op));
			compare("odd_slot.rt", 32'(odd_slot.rt), 32'(r.od_rt));
		end
		if (r.od_valid && r.imm_chk) begin
			compare("odd_slot.imm", 32'(odd_slot.imm), 32'(r.od_imm));
		end
		compare("stall", 32'(stall), 32'(r.stall));
		if (r.stall) begin
			compare("stall_pc", 32'(stall_pc), 32'(r.spc));
		end
	endtask

	initial begin
		int wait_cnt;
		row_t r;
		void'($urandom(32'ha916));
		reset = 1'b1;
		instr_pair = '0;
		pc = '0;
		branch_taken = 1'b0;
		branch_pc = '0;
		build_table();
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		wait_cnt = 0;
		while (!stage_idle() && wait_cnt < 20) begin
			@(negedge clk);
			wait_cnt++;
		end
		if (!stage_idle()) begin
			$display("stage did not settle to its reset state after reset release");
			$display("SOME TESTS FAILED");
			$finish;
		end else begin
			for (int i = 0; i <= rows.size(); i++) begin
				@(posedge clk);
				r = (i < rows.size()) ? rows[i] : '0;
				instr_pair <= {r.first, r.second};
				pc <= r.pc;
				branch_taken <= r.br;
				branch_pc <= r.bpc;
				@(negedge clk);
				if (i > 0) begin
					check_row(rows[i-1]);    // answer to the previous row
				end
			end
			$display("errors: %0d", errors);
			if (errors == 0) begin
				$display("ALL TESTS PASSED");
			end else begin
				$display("SOME TESTS FAILED");
			end
			$finish;
		end
	end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module spu_decode_tb -f all.f -o spu_decode_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/spu_decode_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "ALL TESTS PASSED" sim.log; then
	exit 0
else
	echo "pass message not found in sim.log"
	exit 1
fi

// File: source/instr_decoder.sv
`timescale 1ns/10ps

module instr_decoder (
	input  spu_isa_pkg::instr_word_t   word,
	output spu_issue_pkg::decoded_op_t op
);

	spu_issue_pkg::decoded_op_t base;    // fields shared by most formats
	spu_issue_pkg::decoded_op_t even_op;
	spu_issue_pkg::decoded_op_t odd_op;

	always_comb begin
		base = '0;
		base.valid = (word != '0);
		base.instr = word;
		base.opcode = word[0:10];
		base.rt = word[25:31];
		base.ra = word[18:24];
		base.rb = word[11:17];
		base.rc = word[25:31];    // store data and branch condition live in the rt field
		base.ra_used = 1'b1;
		base.rb_used = 1'b1;
		base.reg_write = 1'b1;
	end

	always_comb begin
		even_op = base;
		if (word[0:3] == spu_isa_pkg::OP_MPYA[0:3] || word[0:3] == spu_isa_pkg::OP_FMA[0:3]) begin
			even_op.format = spu_isa_pkg::fmt_rrr;
			even_op.opcode = {word[0:3], 7'b0};
			even_op.unit = spu_issue_pkg::unit_fp;
			even_op.rt = word[4:10];    // rrr moves rt to the front
			even_op.rc_used = 1'b1;
		end else if (word[0:6] == spu_isa_pkg::OP_ILA[0:6]) begin
			even_op.format = spu_isa_pkg::fmt_ri18;
			even_op.opcode = {word[0:6], 4'b0};
			even_op.unit = spu_issue_pkg::unit_fx1;
			even_op.imm = word[7:24];
			even_op.ra_used = 1'b0;
			even_op.rb_used = 1'b0;
		end else if (word[0:7] inside {spu_isa_pkg::OP_AI[0:7], spu_isa_pkg::OP_AHI[0:7],
				spu_isa_pkg::OP_ANDI[0:7], spu_isa_pkg::OP_ORI[0:7],
				spu_isa_pkg::OP_XORI[0:7], spu_isa_pkg::OP_CEQI[0:7]}) begin
			even_op.format = spu_isa_pkg::fmt_ri10;
			even_op.opcode = {word[0:7], 3'b0};
			even_op.unit = spu_issue_pkg::unit_fx1;
			even_op.imm = spu_isa_pkg::imm_t'($signed(word[8:17]));
			even_op.rb_used = 1'b0;
		end else if (word[0:8] == spu_isa_pkg::OP_ILH[0:8]) begin
			even_op.format = spu_isa_pkg::fmt_ri16;
			even_op.opcode = {word[0:8], 2'b0};
			even_op.unit = spu_issue_pkg::unit_fx1;
			even_op.imm = spu_isa_pkg::imm_t'($signed(word[9:24]));
			even_op.ra_used = 1'b0;
			even_op.rb_used = 1'b0;
		end else begin
			case (word[0:10])    // rr, then ri7
				spu_isa_pkg::OP_MPY, spu_isa_pkg::OP_FA, spu_isa_pkg::OP_FM:
					even_op.unit = spu_issue_pkg::unit_fp;
				spu_isa_pkg::OP_SHL, spu_isa_pkg::OP_ROT:
					even_op.unit = spu_issue_pkg::unit_fx2;
				spu_isa_pkg::OP_CNTB: begin
					even_op.unit = spu_issue_pkg::unit_byte;
					even_op.rb_used = 1'b0;
				end
				spu_isa_pkg::OP_AVGB:
					even_op.unit = spu_issue_pkg::unit_byte;
				spu_isa_pkg::OP_A, spu_isa_pkg::OP_AH, spu_isa_pkg::OP_SF, spu_isa_pkg::OP_AND,
				spu_isa_pkg::OP_OR, spu_isa_pkg::OP_XOR, spu_isa_pkg::OP_CEQ, spu_isa_pkg::OP_CGT:
					even_op.unit = spu_issue_pkg::unit_fx1;
				spu_isa_pkg::OP_NOP: begin
					even_op.unit = spu_issue_pkg::unit_fp;
					even_op.ra_used = 1'b0;
					even_op.rb_used = 1'b0;
					even_op.reg_write = 1'b0;
				end
				spu_isa_pkg::OP_SHLI, spu_isa_pkg::OP_ROTI: begin
					even_op.format = spu_isa_pkg::fmt_ri7;
					even_op.unit = spu_issue_pkg::unit_fx2;
					even_op.imm = spu_isa_pkg::imm_t'($signed(word[11:17]));
					even_op.rb_used = 1'b0;
				end
				default: even_op.valid = 1'b0;
			endcase
		end
	end

	always_comb begin
		odd_op = base;
		odd_op.is_odd = 1'b1;
		odd_op.rb_used = 1'b0;    // only a few odd ops read rb
		if (word[0:7] == spu_isa_pkg::OP_LQD[0:7] || word[0:7] == spu_isa_pkg::OP_STQD[0:7]) begin
			odd_op.format = spu_isa_pkg::fmt_ri10;
			odd_op.opcode = {word[0:7], 3'b0};
			odd_op.unit = spu_issue_pkg::unit_ls;
			odd_op.imm = spu_isa_pkg::imm_t'($signed(word[8:17]));
			if (word[0:7] == spu_isa_pkg::OP_STQD[0:7]) begin
				odd_op.reg_write = 1'b0;
				odd_op.rc_used = 1'b1;
			end
		end else if (word[0:8] inside {spu_isa_pkg::OP_LQA[0:8], spu_isa_pkg::OP_STQA[0:8],
				spu_isa_pkg::OP_BR[0:8], spu_isa_pkg::OP_BRSL[0:8],
				spu_isa_pkg::OP_BRZ[0:8], spu_isa_pkg::OP_BRNZ[0:8]}) begin
			odd_op.format = spu_isa_pkg::fmt_ri16;
			odd_op.opcode = {word[0:8], 2'b0};
			odd_op.imm = spu_isa_pkg::imm_t'($signed(word[9:24]));
			odd_op.ra_used = 1'b0;
			odd_op.unit = spu_issue_pkg::unit_branch;
			odd_op.reg_write = 1'b0;
			case (word[0:8])
				spu_isa_pkg::OP_LQA[0:8]: begin
					odd_op.unit = spu_issue_pkg::unit_ls;
					odd_op.reg_write = 1'b1;
				end
				spu_isa_pkg::OP_STQA[0:8]: begin
					odd_op.unit = spu_issue_pkg::unit_ls;
					odd_op.rc_used = 1'b1;
				end
				spu_isa_pkg::OP_BRSL[0:8]: odd_op.reg_write = 1'b1;    // link register
				spu_isa_pkg::OP_BR[0:8]: odd_op.rc_used = 1'b0;
				default: odd_op.rc_used = 1'b1;    // brz and brnz test rt
			endcase
		end else begin
			case (word[0:10])
				spu_isa_pkg::OP_SHLQBI, spu_isa_pkg::OP_ROTQBY: begin
					odd_op.unit = spu_issue_pkg::unit_perm;
					odd_op.rb_used = 1'b1;
				end
				spu_isa_pkg::OP_GBB: odd_op.unit = spu_issue_pkg::unit_perm;
				spu_isa_pkg::OP_LQX: begin
					odd_op.unit = spu_issue_pkg::unit_ls;
					odd_op.rb_used = 1'b1;
				end
				spu_isa_pkg::OP_STQX: begin
					odd_op.unit = spu_issue_pkg::unit_ls;
					odd_op.rb_used = 1'b1;
					odd_op.rc_used = 1'b1;
					odd_op.reg_write = 1'b0;
				end
				spu_isa_pkg::OP_BI: begin
					odd_op.unit = spu_issue_pkg::unit_branch;
					odd_op.reg_write = 1'b0;
				end
				spu_isa_pkg::OP_LNOP: begin
					odd_op.unit = spu_issue_pkg::unit_perm;
					odd_op.ra_used = 1'b0;
					odd_op.reg_write = 1'b0;
				end
				default: odd_op.valid = 1'b0;
			endcase
		end
	end

	always_comb begin
		if (even_op.valid) begin
			op = even_op;
		end else if (odd_op.valid) begin
			op = odd_op;
		end else begin
			op = '0;    // empty or unknown word
		end
	end

endmodule

// File: source/issue_control.sv
`timescale 1ns/10ps

module issue_control (
	input  logic                       clk,
	input  logic                       reset,
	input  spu_issue_pkg::instr_pair_t instr_pair,
	input  spu_isa_pkg::pc_t           pc,
	input  logic                       branch_taken,
	input  spu_isa_pkg::pc_t           branch_pc,
	input  spu_issue_pkg::decoded_op_t first,
	input  spu_issue_pkg::decoded_op_t second,
	input  logic                       stall_first,
	input  logic                       stall_second,
	output spu_isa_pkg::instr_word_t   first_word,
	output spu_isa_pkg::instr_word_t   second_word,
	output spu_issue_pkg::decoded_op_t even_slot,
	output spu_issue_pkg::decoded_op_t odd_slot,
	output logic                       stall,
	output spu_isa_pkg::pc_t           stall_pc
);

	spu_issue_pkg::instr_pair_t held_q;      // words waiting for replay
	spu_issue_pkg::instr_pair_t cur_pair;
	spu_isa_pkg::pc_t           cur_pc;
	logic                       issue_first;
	logic                       issue_second;
	spu_issue_pkg::decoded_op_t even_next;
	spu_issue_pkg::decoded_op_t odd_next;

	// a stalled cycle replays the held words at the refetch pc
	assign cur_pair = stall ? held_q : instr_pair;
	assign cur_pc = stall ? stall_pc : pc;
	assign first_word = cur_pair.first;
	assign second_word = cur_pair.second;

	assign issue_first = first.valid && !stall_first;
	assign issue_second = second.valid && !stall_first && !stall_second;

	always_comb begin
		even_next = '0;
		odd_next = '0;
		if (issue_first) begin
			if (first.is_odd) begin
				odd_next = first;
			end else begin
				even_next = first;
			end
		end
		if (issue_second) begin    // never the same pipe as first here
			if (second.is_odd) begin
				odd_next = second;
			end else begin
				even_next = second;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			even_slot <= '0;
			odd_slot <= '0;
			stall <= 1'b0;
			stall_pc <= '0;
			held_q <= '0;
		end else if (branch_taken) begin
			even_slot <= '0;    // flush
			odd_slot <= '0;
			stall <= 1'b1;
			stall_pc <= branch_pc;
			held_q <= '0;
		end else begin
			even_slot <= even_next;
			odd_slot <= odd_next;
			stall <= stall_first | stall_second;
			stall_pc <= cur_pc;
			if (stall_first) begin
				held_q <= cur_pair;
			end else if (stall_second) begin
				held_q.first <= cur_pair.second;    // blocked word moves up
				held_q.second <= '0;
			end else begin
				held_q <= '0;
			end
		end
	end

endmodule

// File: source/pair_hazard_check.sv
`timescale 1ns/10ps

module pair_hazard_check (
	input  spu_issue_pkg::decoded_op_t first,
	input  spu_issue_pkg::decoded_op_t second,
	input  spu_issue_pkg::reg_mask_t   busy,
	output logic                       stall_first,
	output logic                       stall_second
);

	spu_issue_pkg::reg_mask_t first_target;    // one-hot rt of first, if it writes
	logic                     same_pipe;
	logic                     same_target;
	logic                     first_busy;
	logic                     second_busy;

	// any used source register flagged in the mask
	function automatic logic reads_mask(
		input spu_issue_pkg::decoded_op_t op,
		input spu_issue_pkg::reg_mask_t   mask
	);
		return (op.ra_used && mask[op.ra]) ||
			(op.rb_used && mask[op.rb]) ||
			(op.rc_used && mask[op.rc]);
	endfunction

	assign first_target = (first.valid && first.reg_write) ?
		(spu_issue_pkg::reg_mask_t'(1) << first.rt) : '0;

	// structural, both need the same pipe
	assign same_pipe = first.valid && second.valid && (first.is_odd == second.is_odd);

	// waw inside the pair
	assign same_target = second.valid && second.reg_write && first_target[second.rt];

	assign first_busy = reads_mask(first, busy);

	// raw on an in-flight result or on the first word's target
	assign second_busy = reads_mask(second, busy | first_target);

	assign stall_first = first.valid && first_busy;
	assign stall_second = second.valid && (same_pipe || same_target || second_busy);

endmodule

// File: source/spu_decode.sv
`timescale 1ns/10ps

module spu_decode #(
	parameter int FP_LATENCY   = 6,
	parameter int FX2_LATENCY  = 4,
	parameter int BYTE_LATENCY = 4,
	parameter int FX1_LATENCY  = 2,
	parameter int PERM_LATENCY = 4,
	parameter int LS_LATENCY   = 6
) (
	input  logic                       clk,
	input  logic                       reset,
	input  spu_issue_pkg::instr_pair_t instr_pair,
	input  spu_isa_pkg::pc_t           pc,
	input  logic                       branch_taken,
	input  spu_isa_pkg::pc_t           branch_pc,
	output spu_issue_pkg::decoded_op_t even_slot,
	output spu_issue_pkg::decoded_op_t odd_slot,
	output logic                       stall,
	output spu_isa_pkg::pc_t           stall_pc
);

	spu_isa_pkg::instr_word_t   first_word;
	spu_isa_pkg::instr_word_t   second_word;
	spu_issue_pkg::decoded_op_t first_op;
	spu_issue_pkg::decoded_op_t second_op;
	spu_issue_pkg::reg_mask_t   busy;       // registers with results still pending
	logic                       stall_first;
	logic                       stall_second;

	issue_control issue_control_i (.clk, .reset, .instr_pair, .pc, .branch_taken, .branch_pc,
		.first(first_op), .second(second_op), .stall_first, .stall_second,
		.first_word, .second_word, .even_slot, .odd_slot, .stall, .stall_pc);

	instr_decoder first_decoder (.word(first_word), .op(first_op));
	instr_decoder second_decoder (.word(second_word), .op(second_op));

	pair_hazard_check pair_hazard_check_i (.first(first_op), .second(second_op), .busy,
		.stall_first, .stall_second);

	write_tracker #(
		.FP_LATENCY(FP_LATENCY), .FX2_LATENCY(FX2_LATENCY), .BYTE_LATENCY(BYTE_LATENCY),
		.FX1_LATENCY(FX1_LATENCY), .PERM_LATENCY(PERM_LATENCY), .LS_LATENCY(LS_LATENCY)
	) write_tracker_i (.clk, .reset, .even_slot, .odd_slot, .busy);

endmodule

// File: source/spu_isa_pkg.sv
package spu_isa_pkg;

	typedef logic [0:31] instr_word_t;    // bit 0 is the msb, isa numbering
	typedef logic [6:0]  reg_addr_t;
	typedef logic [17:0] imm_t;           // sign-extended immediate
	typedef logic [0:10] opcode_t;        // short opcodes padded with zeros on the right
	typedef logic [7:0]  pc_t;

	typedef enum logic [2:0] {
		fmt_rr,
		fmt_rrr,
		fmt_ri7,
		fmt_ri8,
		fmt_ri10,
		fmt_ri16,
		fmt_ri18
	} instr_format_t;

	// even pipe
	localparam opcode_t OP_MPYA   = 11'b1100_0000000;    // rrr
	localparam opcode_t OP_FMA    = 11'b1110_0000000;
	localparam opcode_t OP_ILA    = 11'b0100001_0000;    // ri18
	localparam opcode_t OP_ILH    = 11'b010000011_00;    // ri16
	localparam opcode_t OP_AI     = 11'b00011100_000;    // ri10
	localparam opcode_t OP_AHI    = 11'b00011101_000;
	localparam opcode_t OP_ANDI   = 11'b00010100_000;
	localparam opcode_t OP_ORI    = 11'b00000100_000;
	localparam opcode_t OP_XORI   = 11'b01000100_000;
	localparam opcode_t OP_CEQI   = 11'b01111100_000;
	localparam opcode_t OP_MPY    = 11'b01111000100;     // rr
	localparam opcode_t OP_FA     = 11'b01011000100;
	localparam opcode_t OP_FM     = 11'b01011000110;
	localparam opcode_t OP_SHL    = 11'b00001011011;
	localparam opcode_t OP_ROT    = 11'b00001011000;
	localparam opcode_t OP_CNTB   = 11'b01010110100;
	localparam opcode_t OP_AVGB   = 11'b00011010011;
	localparam opcode_t OP_A      = 11'b00011000000;
	localparam opcode_t OP_AH     = 11'b00011001000;
	localparam opcode_t OP_SF     = 11'b00001000000;
	localparam opcode_t OP_AND    = 11'b00011000001;
	localparam opcode_t OP_OR     = 11'b00001000001;
	localparam opcode_t OP_XOR    = 11'b01001000001;
	localparam opcode_t OP_CEQ    = 11'b01111000000;
	localparam opcode_t OP_CGT    = 11'b01001000000;
	localparam opcode_t OP_NOP    = 11'b01000000001;
	localparam opcode_t OP_SHLI   = 11'b00001111011;     // ri7
	localparam opcode_t OP_ROTI   = 11'b00001111000;

	// odd pipe
	localparam opcode_t OP_LQD    = 11'b00110100_000;    // ri10
	localparam opcode_t OP_STQD   = 11'b00100100_000;
	localparam opcode_t OP_LQA    = 11'b001100001_00;    // ri16
	localparam opcode_t OP_STQA   = 11'b001000001_00;
	localparam opcode_t OP_BR     = 11'b001100100_00;
	localparam opcode_t OP_BRSL   = 11'b001100110_00;
	localparam opcode_t OP_BRZ    = 11'b001000000_00;
	localparam opcode_t OP_BRNZ   = 11'b001000010_00;
	localparam opcode_t OP_SHLQBI = 11'b00111011011;     // rr
	localparam opcode_t OP_ROTQBY = 11'b00111011100;
	localparam opcode_t OP_GBB    = 11'b00110110010;
	localparam opcode_t OP_LQX    = 11'b00111000100;
	localparam opcode_t OP_STQX   = 11'b00101000100;
	localparam opcode_t OP_BI     = 11'b00110101000;
	localparam opcode_t OP_LNOP   = 11'b00000000001;

endpackage

// File: source/spu_issue_pkg.sv
package spu_issue_pkg;

	typedef enum logic [2:0] {
		unit_none,
		unit_fp,        // fp through fx1 sit in the even pipe
		unit_fx2,
		unit_byte,
		unit_fx1,
		unit_perm,      // odd pipe from here on
		unit_ls,
		unit_branch
	} exec_unit_t;

	typedef logic [127:0] reg_mask_t;    // one bit per register

	typedef struct packed {
		logic                       valid;
		logic                       is_odd;
		exec_unit_t                 unit;
		spu_isa_pkg::instr_format_t format;
		spu_isa_pkg::opcode_t       opcode;
		spu_isa_pkg::reg_addr_t     rt;
		spu_isa_pkg::reg_addr_t     ra;
		spu_isa_pkg::reg_addr_t     rb;
		spu_isa_pkg::reg_addr_t     rc;
		logic                       ra_used;
		logic                       rb_used;
		logic                       rc_used;
		logic                       reg_write;
		spu_isa_pkg::imm_t          imm;
		spu_isa_pkg::instr_word_t   instr;    // word as fetched
	} decoded_op_t;

	typedef struct packed {
		spu_isa_pkg::instr_word_t first;     // older word of the pair
		spu_isa_pkg::instr_word_t second;
	} instr_pair_t;

endpackage

// File: source/write_tracker.sv
`timescale 1ns/10ps

module write_tracker #(
	parameter int FP_LATENCY   = 6,
	parameter int FX2_LATENCY  = 4,
	parameter int BYTE_LATENCY = 4,
	parameter int FX1_LATENCY  = 2,
	parameter int PERM_LATENCY = 4,
	parameter int LS_LATENCY   = 6
) (
	input  logic                       clk,
	input  logic                       reset,
	input  spu_issue_pkg::decoded_op_t even_slot,
	input  spu_issue_pkg::decoded_op_t odd_slot,
	output spu_issue_pkg::reg_mask_t   busy
);

	function automatic int max2(input int a, input int b);
		return (a > b) ? a : b;
	endfunction

	localparam int MAX_LATENCY = max2(max2(max2(FP_LATENCY, FX2_LATENCY),
		max2(BYTE_LATENCY, FX1_LATENCY)), max2(PERM_LATENCY, LS_LATENCY));
	localparam int COUNT_W = $clog2(MAX_LATENCY + 1);

	typedef logic [COUNT_W-1:0] count_t;

	typedef struct packed {
		spu_isa_pkg::reg_addr_t rt;
		logic                   write;
		count_t                 remain;    // busy cycles left
	} entry_t;

	entry_t                     line_q [2][MAX_LATENCY];    // index 0 even, 1 odd
	spu_issue_pkg::decoded_op_t slot [2];

	assign slot[0] = even_slot;
	assign slot[1] = odd_slot;

	// slot cycle and the decode cycle come off the latency
	function automatic count_t load_count(input spu_issue_pkg::exec_unit_t unit);
		case (unit)
			spu_issue_pkg::unit_fp:   return count_t'(FP_LATENCY - 2);
			spu_issue_pkg::unit_fx2:  return count_t'(FX2_LATENCY - 2);
			spu_issue_pkg::unit_byte: return count_t'(BYTE_LATENCY - 2);
			spu_issue_pkg::unit_fx1:  return count_t'(FX1_LATENCY - 2);
			spu_issue_pkg::unit_perm: return count_t'(PERM_LATENCY - 2);
			spu_issue_pkg::unit_ls:   return count_t'(LS_LATENCY - 2);
			default:                  return '0;
		endcase
	endfunction

	function automatic entry_t age(input entry_t e);
		age = e;
		if (e.remain != '0) begin
			age.remain = e.remain - 1'b1;
		end
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			line_q <= '{default: '0};
		end else begin
			for (int p = 0; p < 2; p++) begin
				line_q[p][0].rt <= slot[p].rt;
				line_q[p][0].write <= slot[p].valid & slot[p].reg_write;
				line_q[p][0].remain <= load_count(slot[p].unit);
				for (int i = 1; i < MAX_LATENCY; i++) begin
					line_q[p][i] <= age(line_q[p][i-1]);
				end
			end
		end
	end

	always_comb begin
		busy = '0;
		for (int p = 0; p < 2; p++) begin
			if (slot[p].valid && slot[p].reg_write) begin
				busy[slot[p].rt] = 1'b1;    // producer sitting in the slot right now
			end
			for (int i = 0; i < MAX_LATENCY; i++) begin
				if (line_q[p][i].write && line_q[p][i].remain != '0) begin
					busy[line_q[p][i].rt] = 1'b1;
				end
			end
		end
	end

endmodule
